// File: rtl/uart_echo_pkg.sv
//====================
// uart echo package
// widths, byte and length types, controller states
// and the rx/tx handshake structs
//====================
package uart_echo_pkg;

	localparam int DATA_W = 8;
	localparam int LEN_W  = 7;

	localparam int MAX_FRAME_BYTES   = 64;
	// two slots stay free for the terminator
	localparam int MAX_PAYLOAD_BYTES = MAX_FRAME_BYTES - 2;

	typedef logic [DATA_W-1:0]                  byte_t;
	typedef logic [LEN_W-1:0]                   frame_len_t;
	typedef logic [$clog2(MAX_FRAME_BYTES)-1:0] buf_addr_t;

	// ascii '&' is sent twice after the payload
	localparam byte_t FRAME_TERM = 8'h26;

	typedef enum logic [1:0] {
		IDLE,
		COLLECT,
		SEND,
		REPORT
	} frame_state_e;

	typedef struct packed {
		byte_t data;
		logic  valid;
	} rx_beat_s;

	typedef struct packed {
		byte_t data;
		logic  req;
	} tx_cmd_s;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
//====================
// uart receiver
// 8 data bits, one stop bit, mid-bit sampling
// framing errors drop the byte
//====================
module uart_rx #(
	parameter int CLK_FREQ_HZ = 10_000_000,
	parameter int BAUD_RATE   = 115_200
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    rx_line,
	output uart_echo_pkg::rx_beat_s rx_beat
);
	import uart_echo_pkg::*;

	localparam int BIT_CLKS  = CLK_FREQ_HZ / BAUD_RATE;
	localparam int HALF_CLKS = BIT_CLKS / 2;
	localparam int CNT_W     = $clog2(BIT_CLKS);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e        state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic             beat_valid;
	byte_t            shift_q;
	logic             half_tick;
	logic             bit_tick;

	assign half_tick = (clk_cnt == CNT_W'(HALF_CLKS - 1));
	assign bit_tick  = (clk_cnt == CNT_W'(BIT_CLKS - 1));

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= RX_IDLE;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (half_tick) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// line back high means a glitch, not a start bit
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'(DATA_W - 1))
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						clk_cnt    <= '0;
						beat_valid <= rx_sync;
						state      <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_tick)
			shift_q <= {rx_sync, shift_q[DATA_W-1:1]};
	end

	assign rx_beat = '{data: shift_q, valid: beat_valid};

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
//====================
// uart transmitter
// start bit, 8 data bits lsb first, two stop bits
//====================
module uart_tx #(
	parameter int CLK_FREQ_HZ = 10_000_000,
	parameter int BAUD_RATE   = 115_200
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  uart_echo_pkg::tx_cmd_s tx_cmd,
	output logic                   tx_line,
	output logic                   tx_done
);
	import uart_echo_pkg::*;

	localparam int BIT_CLKS   = CLK_FREQ_HZ / BAUD_RATE;
	localparam int CNT_W      = $clog2(BIT_CLKS);
	// start + data + two stop
	localparam int FRAME_BITS = DATA_W + 3;

	logic                  busy;
	logic [CNT_W-1:0]      clk_cnt;
	logic [3:0]            bit_cnt;
	logic [FRAME_BITS-1:0] shift_q;
	logic                  bit_end;

	assign bit_end = (clk_cnt == CNT_W'(BIT_CLKS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				clk_cnt <= '0;
				bit_cnt <= '0;
				if (tx_cmd.req)
					busy <= 1'b1;
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'(FRAME_BITS - 1)) begin
					// end of second stop bit
					busy    <= 1'b0;
					tx_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// stop bits fill in from the top as the frame shifts out
	always_ff @(posedge sys_clk) begin
		if (!busy && tx_cmd.req)
			shift_q <= {2'b11, tx_cmd.data, 1'b0};
		else if (busy && bit_end)
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

	assign tx_line = busy ? shift_q[0] : 1'b1;

endmodule

// File: rtl/uart_frame_ctrl.sv
`timescale 1ns/1ps
//====================
// uart frame controller
// buffers a frame until the line goes idle, appends "&&"
// and echoes it back, then reports the length
//====================
module uart_frame_ctrl #(
	parameter int CLK_FREQ_HZ = 10_000_000,
	parameter int BAUD_RATE   = 115_200,
	parameter int IDLE_CLKS   = 3000
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      rx_line,
	output logic                      tx_line,
	output logic                      frame_done,
	output uart_echo_pkg::frame_len_t frame_len
);
	import uart_echo_pkg::*;

	localparam int IDLE_W = $clog2(IDLE_CLKS + 1);

	frame_state_e      state;
	byte_t             frame_buf [MAX_FRAME_BYTES];
	frame_len_t        wr_cnt;
	frame_len_t        rd_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	rx_beat_s          rx_beat;
	tx_cmd_s           tx_cmd;
	logic              tx_done;
	logic              tx_req;
	byte_t             tx_data;
	logic              take_byte;
	logic              timeout;
	logic              issue;
	logic              last_done;

	// bytes past the payload limit are dropped, but still count as activity
	assign take_byte = rx_beat.valid && (state == IDLE || state == COLLECT) &&
		(wr_cnt < frame_len_t'(MAX_PAYLOAD_BYTES));
	assign timeout   = (state == COLLECT) && !rx_beat.valid &&
		(idle_cnt == IDLE_W'(IDLE_CLKS - 1));
	assign issue     = timeout || (state == SEND && tx_done && rd_cnt != wr_cnt);
	assign last_done = (state == SEND) && tx_done && (rd_cnt == wr_cnt);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= IDLE;
			wr_cnt    <= '0;
			rd_cnt    <= '0;
			idle_cnt  <= '0;
			tx_req    <= 1'b0;
			frame_len <= '0;
		end else begin
			tx_req <= issue;
			if (take_byte)
				wr_cnt <= wr_cnt + 1'b1;
			if (issue)
				rd_cnt <= rd_cnt + 1'b1;
			case (state)
				IDLE: begin
					idle_cnt <= '0;
					if (rx_beat.valid)
						state <= COLLECT;
				end
				COLLECT: begin
					if (rx_beat.valid) begin
						idle_cnt <= '0;
					end else if (timeout) begin
						// room for the terminator pair
						idle_cnt <= '0;
						wr_cnt   <= wr_cnt + frame_len_t'(2);
						state    <= SEND;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				SEND: begin
					if (last_done) begin
						frame_len <= wr_cnt;
						state     <= REPORT;
					end
				end
				REPORT: begin
					wr_cnt <= '0;
					rd_cnt <= '0;
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// frame buffer and tx data register
	always_ff @(posedge sys_clk) begin
		if (take_byte)
			frame_buf[buf_addr_t'(wr_cnt)] <= rx_beat.data;
		if (timeout) begin
			frame_buf[buf_addr_t'(wr_cnt)]                    <= FRAME_TERM;
			frame_buf[buf_addr_t'(wr_cnt + frame_len_t'(1))] <= FRAME_TERM;
		end
		if (issue)
			tx_data <= frame_buf[buf_addr_t'(rd_cnt)];
	end

	assign tx_cmd     = '{data: tx_data, req: tx_req};
	assign frame_done = (state == REPORT);

	uart_rx #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (rx_line),
		.rx_beat   (rx_beat)
	);

	uart_tx #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_cmd    (tx_cmd),
		.tx_line   (tx_line),
		.tx_done   (tx_done)
	);

endmodule

// File: rtl/uart_echo_top.sv
`timescale 1ns/1ps
//====================
// uart echo top
// sets clock, baud and idle timeout for the frame echo
//====================
module uart_echo_top #(
	parameter int CLK_FREQ_HZ = 10_000_000,
	parameter int BAUD_RATE   = 115_200,
	parameter int IDLE_CLKS   = 3000
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      rx_line,
	output logic                      tx_line,
	output logic                      frame_done,
	output uart_echo_pkg::frame_len_t frame_len
);

	// idle timeout is counted in sys_clk cycles
	uart_frame_ctrl #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE),
		.IDLE_CLKS   (IDLE_CLKS)
	) u_uart_frame_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_line    (rx_line),
		.tx_line    (tx_line),
		.frame_done (frame_done),
		.frame_len  (frame_len)
	);

endmodule

// File: dv/uart_echo_tb.sv
`timescale 1ns/1ps
//====================
// uart echo testbench
// plays frames from the data file into rx_line, decodes
// the echo on tx_line and checks bytes and frame report
//====================
module uart_echo_tb;

	localparam int CLK_FREQ_HZ = 10_000_000;
	localparam int BAUD_RATE   = 115_200;
	localparam int IDLE_CLKS   = 3000;
	localparam int BIT_CLKS    = CLK_FREQ_HZ / BAUD_RATE;
	localparam int PAYLOAD_MAX = 62;
	localparam logic [7:0] TERM_BYTE = 8'h26;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       rx_line;
	logic       tx_line;
	logic       frame_done;
	logic [6:0] frame_len;

	int         seed = 81270;
	int         check_errs = 0;
	int         other_errs = 0;
	int         done_cnt = 0;
	int         tx_starts = 0;
	int         n_frames = 0;
	logic [7:0] mon_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] stim_q[$];
	bit         bad_q[$];
	byte        tags[$];
	int         vals[$];
	bit         flags[$];

	uart_echo_top #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE),
		.IDLE_CLKS   (IDLE_CLKS)
	) DUT (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_line    (rx_line),
		.tx_line    (tx_line),
		.frame_done (frame_done),
		.frame_len  (frame_len)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	function automatic void report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		check_errs++;
	endfunction

	// start, 8 data lsb first, stop; a bad stop gets one extra idle bit
	task automatic send_byte(input logic [7:0] data, input bit bad_stop);
		logic [10:0] bits;
		bits = {1'b1, ~bad_stop, data, 1'b0};
		for (int i = 0; i < (bad_stop ? 11 : 10); i++) begin
			rx_line <= bits[i];
			repeat (BIT_CLKS) @(posedge sys_clk);
		end
	endtask

	task automatic run_frame(input int late, input int frame_idx);
		int waited;
		int start_done;
		start_done = done_cnt;
		mon_q.delete();
		@(posedge sys_clk);
		foreach (stim_q[i])
			send_byte(stim_q[i], bad_q[i]);
		if (late > 0) begin
			// these land while the echo is running
			@(negedge tx_line);
			@(posedge sys_clk);
			repeat (late)
				send_byte(8'($random(seed)), 1'b0);
		end
		waited = 0;
		while (done_cnt == start_done && waited < IDLE_CLKS + 66 * 11 * BIT_CLKS) begin
			@(posedge sys_clk);
			waited++;
		end
		if (done_cnt == start_done) begin
			$display("frame %0d: no frame_done pulse arrived in time", frame_idx);
			other_errs++;
		end
		// long quiet gap to catch a stray frame or stray byte
		repeat (2 * IDLE_CLKS + 12 * BIT_CLKS) @(posedge sys_clk);
		if (done_cnt != start_done + 1)
			report_mismatch($sformatf("frame %0d: %0d frame_done pulses, expected 1",
				frame_idx, done_cnt - start_done));
		if (mon_q.size() != exp_q.size())
			report_mismatch($sformatf("frame %0d: %0d bytes echoed, expected %0d",
				frame_idx, mon_q.size(), exp_q.size()));
		foreach (exp_q[i]) begin
			if (i < mon_q.size() && mon_q[i] !== exp_q[i])
				report_mismatch($sformatf("frame %0d byte %0d: got %02h, expected %02h",
					frame_idx, i, mon_q[i], exp_q[i]));
		end
	endtask

	// decode tx_line at mid-bit
	initial begin : tx_monitor
		logic [7:0] rx_byte;
		forever begin
			@(negedge tx_line);
			tx_starts++;
			repeat (BIT_CLKS / 2) @(posedge sys_clk);
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(posedge sys_clk);
				rx_byte[i] = tx_line;
			end
			repeat (BIT_CLKS) @(posedge sys_clk);
			if (tx_line !== 1'b1)
				report_mismatch("stop bit low on tx_line");
			mon_q.push_back(rx_byte);
		end
	end

	// report must follow the last echoed byte
	always @(negedge sys_clk) begin
		if (sys_rst_n && frame_done) begin
			done_cnt++;
			if (mon_q.size() != exp_q.size())
				report_mismatch($sformatf("frame_done after %0d of %0d echoed bytes",
					mon_q.size(), exp_q.size()));
			if (frame_len !== 7'(exp_q.size()))
				report_mismatch($sformatf("frame_len %0d, expected %0d",
					frame_len, exp_q.size()));
		end
	end

	initial begin : watchdog
		wait (n_frames > 0);
		repeat (n_frames * (64 * 11 * 2 * BIT_CLKS + IDLE_CLKS) + 20 * IDLE_CLKS)
			@(posedge sys_clk);
		$display("timeout: run went past the cycle budget for %0d frames", n_frames);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main_flow
		int fd;
		string line;
		int pending;
		int late;
		int frame_idx;
		int val;
		int flag;
		rx_line   = 1'b1;
		sys_rst_n = 1'b0;
		pending   = 0;
		late      = 0;
		frame_idx = 0;
		fd = $fopen("dv/uart_echo_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the data file dv/uart_echo_testdata.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					val  = 0;
					flag = 0;
					if (line[0] == "D" || line[0] == "X")
						void'($sscanf(line.substr(2, line.len() - 1), "%h %d", val, flag));
					else
						void'($sscanf(line.substr(2, line.len() - 1), "%d", val));
					tags.push_back(line[0]);
					vals.push_back(val);
					flags.push_back(flag[0]);
					if (line[0] == "F")
						n_frames++;
				end
			end
			$fclose(fd);

			repeat (16) @(posedge sys_clk);
			sys_rst_n <= 1'b1;
			repeat (4 * BIT_CLKS) @(posedge sys_clk);
			if (tx_line !== 1'b1 || frame_len !== 7'd0)
				report_mismatch("tx_line not idle high or frame_len not zero after reset");
			if (done_cnt != 0 || tx_starts != 0)
				report_mismatch("tx activity before the first stimulus");

			for (int i = 0; i < tags.size(); i++) begin
				case (tags[i])
					"F": begin
						late = vals[i];
						frame_idx++;
						stim_q.delete();
						bad_q.delete();
						exp_q.delete();
					end
					"D": begin
						stim_q.push_back(8'(vals[i]));
						bad_q.push_back(flags[i]);
					end
					"R": begin
						// only the first 62 bytes of an overflow frame come back
						for (int k = 0; k < vals[i]; k++) begin
							stim_q.push_back(8'($random(seed)));
							bad_q.push_back(1'b0);
							if (k < PAYLOAD_MAX)
								exp_q.push_back(stim_q[$]);
						end
						exp_q.push_back(TERM_BYTE);
						exp_q.push_back(TERM_BYTE);
					end
					"E": begin
						pending = vals[i];
						if (pending == 0)
							run_frame(late, frame_idx);
					end
					"X": begin
						exp_q.push_back(8'(vals[i]));
						pending--;
						if (pending == 0)
							run_frame(late, frame_idx);
					end
					default: begin
						$display("unknown record tag in the data file at record %0d", i);
						other_errs++;
					end
				endcase
			end

			$display("summary: %0d frames, %0d check errors, %0d other errors",
				frame_idx, check_errs, other_errs);
			if (check_errs + other_errs == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

// File: dv/uart_echo_testdata.txt
# F late_count | D byte_hex bad_stop | R random_count | E expected_count | X byte_hex
# bad_stop 1 sends a low stop bit and a frame runs after its last X line or right at E 0
F 0
D 48 0
D 69 0
E 4
X 48
X 69
X 26
X 26
F 0
D 41 0
D 42 1
D 43 0
E 4
X 41
X 43
X 26
X 26
F 0
R 70
E 0
F 3
D 5a 0
E 3
X 5a
X 26
X 26

// File: list.f
rtl/uart_echo_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_frame_ctrl.sv
rtl/uart_echo_top.sv
dv/uart_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the uart echo testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module uart_echo_tb -o sim_uart_echo &&
./obj_dir/sim_uart_echo | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
